/* sifhTop.f */
common/sifhPkg.sv
histogram/histRam.sv
histogram/histBuilder.sv
rtl/peakFinder.sv
rtl/sifhCtrl.sv
rtl/apbRegs.sv
rtl/sifhTop.sv
verification/sifhTop_sva.sv
verification/sifhTb.sv

/* run.sh */
#!/usr/bin/env bash
# build the histogram regression with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sifhTop.f --top-module sifhTb -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if grep -q "%Error" sim.log || ! grep -q "Regression passed" sim.log; then
    exit 1
fi

/* verification/sifhTb.sv */
`timescale 1ns/10ps

module sifhTb;

    localparam int PERIOD     = 10;
    localparam int RUNS       = 4;
    localparam int PASS_LEN   = 64;                 // accepted samples per pass
    localparam int MAX_CYCLES = RUNS * (2 * PASS_LEN * 4 + 100);

    logic                clk        = 1'b0;
    logic                res;
    sifhPkg::apbReq_t    apbReq;
    sifhPkg::apbRsp_t    apbRsp;
    sifhPkg::timestamp_t data;
    logic                dataValid;
    logic                tdcEnable;
    logic                irq;

    int                  seed       = 52;
    int                  cycles     = 0;
    sifhPkg::timestamp_t target     = '0;          // cluster centre
    logic                repeatMode = 1'b0;        // cluster hits target exactly
    logic                fullRate   = 1'b0;        // dataValid every cycle
    sifhPkg::timestamp_t samples[$];                // accepted samples of all runs
    int                  passCount  = 0;
    int                  passDone   = 0;
    logic                prevEn     = 1'b0;

    sifhTop uut (
        .clk       (clk),
        .res       (res),
        .apbReq    (apbReq),
        .apbRsp    (apbRsp),
        .data      (data),
        .dataValid (dataValid),
        .tdcEnable (tdcEnable),
        .irq       (irq)
    );

    initial begin
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            failRun($sformatf("Fail at %0t ns: %s is 0x%0h, expected 0x%0h",
                              $time, what, actual, expected));
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            failRun($sformatf("Timeout: no finished measurement within %0d cycles",
                              MAX_CYCLES));
        end
    end

    task automatic writeReg(input sifhPkg::apbAddr_t addr, input logic [31:0] wdata);
        @(negedge clk);
        apbReq.psel    = 1'b1;                      // setup phase
        apbReq.penable = 1'b0;
        apbReq.pwrite  = 1'b1;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(negedge clk);
        apbReq.penable = 1'b1;
        #(PERIOD / 4);
        checkEq(apbRsp.pready, 1'b1, "pready");
        checkEq(apbRsp.pslverr, 1'b0, "pslverr");
        @(negedge clk);
        apbReq = '0;
    endtask

    task automatic readReg(input sifhPkg::apbAddr_t addr, output logic [31:0] rdata);
        @(negedge clk);
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = 1'b0;
        apbReq.paddr   = addr;
        apbReq.pwdata  = '0;
        @(negedge clk);
        apbReq.penable = 1'b1;
        #(PERIOD / 4);                              // prdata settled before the edge
        rdata = apbRsp.prdata;
        checkEq(apbRsp.pready, 1'b1, "pready");
        checkEq(apbRsp.pslverr, 1'b0, "pslverr");
        @(negedge clk);
        apbReq = '0;
    endtask

    // half the hits cluster near the target and the rest spread over the range
    function automatic sifhPkg::timestamp_t nextTimestamp();
        logic                pick;
        logic [4:0]          jitter;
        sifhPkg::timestamp_t ts;
        pick   = 1'($random(seed));
        jitter = 5'($random(seed));
        if (!pick) begin
            ts = sifhPkg::timestamp_t'($random(seed));
        end else if (repeatMode) begin
            ts = target;
        end else begin
            ts = target + sifhPkg::timestamp_t'(jitter) - 12'd16;
        end
        return ts;
    endfunction

    // TDC model with one sample per falling edge
    initial begin
        data      = '0;
        dataValid = 1'b0;
        forever begin
            @(negedge clk);
            if (prevEn && !tdcEnable) begin
                checkEq(passCount, PASS_LEN, "samples accepted in pass");
                passCount = 0;
                passDone  = passDone + 1;
            end
            prevEn    = tdcEnable;
            dataValid = fullRate ? 1'b1 : 1'($random(seed));
            data      = nextTimestamp();
            if (tdcEnable && dataValid) begin
                samples.push_back(data);
                passCount = passCount + 1;
            end
        end
    end

    function automatic logic [3:0] firstMax(input int hist [16]);
        logic [3:0] best;
        int         i;
        best = 4'd0;
        for (i = 1; i < 16; i++) begin
            if (hist[i] > hist[best]) begin
                best = 4'(i);                       // strictly greater so the lowest index wins
            end
        end
        return best;
    endfunction

    task automatic computeExpected(input int first, output logic [7:0] pos,
                                   output logic [7:0] cnt);
        int                  coarseHist [16];
        int                  fineHist [16];
        logic [3:0]          coarsePeak;
        logic [3:0]          finePeak;
        sifhPkg::timestamp_t ts;
        int                  i;
        for (i = 0; i < 16; i++) begin
            coarseHist[i] = 0;
            fineHist[i]   = 0;
        end
        for (i = 0; i < PASS_LEN; i++) begin
            ts = samples[first + i];
            coarseHist[ts[11:8]] = coarseHist[ts[11:8]] + 1;
        end
        coarsePeak = firstMax(coarseHist);
        for (i = PASS_LEN; i < 2 * PASS_LEN; i++) begin
            ts = samples[first + i];
            if (ts[11:8] == coarsePeak) begin       // outside the window still used a slot
                fineHist[ts[7:4]] = fineHist[ts[7:4]] + 1;
            end
        end
        finePeak = firstMax(fineHist);
        pos      = {coarsePeak, finePeak};
        cnt      = 8'(fineHist[finePeak]);
    endtask

    task automatic runMeasurement(input logic repeatRun, input logic fastRun,
                                  input logic startTwice);
        int          first;
        int          passesBefore;
        logic [31:0] rdata;
        logic [7:0]  expPos;
        logic [7:0]  expCnt;
        @(posedge clk);
        target       = sifhPkg::timestamp_t'($random(seed));
        repeatMode   = repeatRun;
        fullRate     = fastRun;
        first        = samples.size();
        passesBefore = passDone;
        writeReg(sifhPkg::REG_CTRL, 32'd1);
        if (startTwice) begin
            readReg(sifhPkg::REG_STATUS, rdata);
            checkEq(rdata[0], 1'b1, "busy after start");
            while (!tdcEnable) @(negedge clk);
            writeReg(sifhPkg::REG_CTRL, 32'd1);    // second start during the coarse pass
        end
        while (!irq) @(negedge clk);
        checkEq(samples.size() - first, 2 * PASS_LEN, "accepted samples per run");
        checkEq(passDone - passesBefore, 2, "finished passes");
        checkEq(tdcEnable, 1'b0, "tdcEnable after finish");
        readReg(sifhPkg::REG_STATUS, rdata);
        checkEq(rdata, 32'd2, "status at done");
        computeExpected(first, expPos, expCnt);
        readReg(sifhPkg::REG_RESULT, rdata);
        checkEq(rdata[7:4], expPos[7:4], "coarse peak bin");
        checkEq(rdata[3:0], expPos[3:0], "fine peak bin");
        checkEq(rdata[15:8], expCnt, "peak count");
        checkEq(rdata[31:16], 16'd0, "result upper bits");
        writeReg(sifhPkg::REG_STATUS, 32'd2);      // clear done
        readReg(sifhPkg::REG_STATUS, rdata);
        checkEq(rdata, 32'd0, "status after clear");
        checkEq(irq, 1'b0, "irq after clear");
    endtask

    initial begin
        logic [31:0] rdata;
        res    = 1'b0;
        apbReq = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        res = 1'b1;
        checkEq(irq, 1'b0, "irq after reset");
        checkEq(tdcEnable, 1'b0, "tdcEnable after reset");
        readReg(sifhPkg::REG_STATUS, rdata);
        checkEq(rdata, 32'd0, "status after reset");
        runMeasurement(1'b0, 1'b0, 1'b0);           // clustered with sparse dataValid
        runMeasurement(1'b1, 1'b1, 1'b0);           // same bin back to back
        runMeasurement(1'b0, 1'b0, 1'b0);           // old counts must be gone
        runMeasurement(1'b0, 1'b1, 1'b1);           // start while busy
        $display("Regression passed");
        $finish;
    end

endmodule

/* verification/sifhTop_sva.sv */
`timescale 1ns/10ps

module sifhTopSva (
    input logic             clk,
    input logic             res,
    input sifhPkg::apbReq_t apbReq,
    input sifhPkg::ramWr_t  ramWr,
    input sifhPkg::ramRd_t  ramRd,
    input logic             tdcEnable,
    input logic             busy,
    input logic             irq,
    input logic             done
);

    enableInBusy: assert property (@(posedge clk) disable iff (!res) tdcEnable |-> busy)
        else $error("tdcEnable high outside a measurement");

    // read and write of one word in the same cycle would return stale data
    noRamCollision: assert property (@(posedge clk) disable iff (!res)
        !(ramWr.we && ramRd.re && ramWr.addr == ramRd.addr))
        else $error("SRAM read and write to the same word");

    setupThenAccess: assert property (@(posedge clk) disable iff (!res)
        apbReq.psel && !apbReq.penable |=> apbReq.penable)
        else $error("APB setup not followed by access");

    enableNeedsSel: assert property (@(posedge clk) disable iff (!res)
        apbReq.penable |-> apbReq.psel)
        else $error("penable without psel");

    irqIsDone: assert property (@(posedge clk) disable iff (!res) irq == done)
        else $error("irq differs from done bit");

endmodule

bind sifhTop sifhTopSva uSva (
    .clk       (clk),
    .res       (res),
    .apbReq    (apbReq),
    .ramWr     (ramWr),
    .ramRd     (ramRd),
    .tdcEnable (tdcEnable),
    .busy      (busy),
    .irq       (irq),
    .done      (uApbRegs.done)
);

/* rtl/sifhTop.sv */
`timescale 1ns/10ps

module sifhTop (
    input  logic                clk,
    input  logic                res,
    input  sifhPkg::apbReq_t    apbReq,
    output sifhPkg::apbRsp_t    apbRsp,
    input  sifhPkg::timestamp_t data,
    input  logic                dataValid,
    output logic                tdcEnable,
    output logic                irq
);

    logic              start;
    logic              busy;
    logic              finish;
    sifhPkg::peakPos_t peakPos;
    sifhPkg::count_t   peakCount;
    sifhPkg::count_t   rdata;
    sifhPkg::ramWr_t   ramWr;
    sifhPkg::ramRd_t   ramRd;

    apbRegs uApbRegs (
        .clk       (clk),
        .res       (res),
        .apbReq    (apbReq),
        .apbRsp    (apbRsp),
        .busy      (busy),
        .finish    (finish),
        .peakPos   (peakPos),
        .peakCount (peakCount),
        .start     (start),
        .irq       (irq)
    );

    sifhCtrl uCtrl (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .data      (data),
        .dataValid (dataValid),
        .tdcEnable (tdcEnable),
        .wr        (ramWr),
        .rd        (ramRd),
        .rdata     (rdata),
        .busy      (busy),
        .finish    (finish),
        .peakPos   (peakPos),
        .peakCount (peakCount)
    );

    histRam uRam (
        .clk   (clk),
        .wr    (ramWr),
        .rd    (ramRd),
        .rdata (rdata)
    );

endmodule

/* rtl/apbRegs.sv */
`timescale 1ns/10ps

module apbRegs (
    input  logic              clk,
    input  logic              res,
    input  sifhPkg::apbReq_t  apbReq,
    output sifhPkg::apbRsp_t  apbRsp,
    input  logic              busy,
    input  logic              finish,
    input  sifhPkg::peakPos_t peakPos,
    input  sifhPkg::count_t   peakCount,
    output logic              start,
    output logic              irq
);

    logic              access;
    logic              wrAccess;
    logic              rdAccess;
    logic              clearDone;
    logic              done;
    sifhPkg::peakPos_t resPos;
    sifhPkg::count_t   resCount;

    assign access    = apbReq.psel && apbReq.penable;   // access phase
    assign wrAccess  = access && apbReq.pwrite;
    assign rdAccess  = access && !apbReq.pwrite;
    assign start     = wrAccess && apbReq.paddr == sifhPkg::REG_CTRL &&
                       apbReq.pwdata[0] && !busy;       // dropped while running
    assign clearDone = wrAccess && apbReq.paddr == sifhPkg::REG_STATUS && apbReq.pwdata[1];
    assign irq       = done;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            done     <= 1'b0;
            resPos   <= '0;
            resCount <= '0;
        end else begin
            if (finish) begin
                done     <= 1'b1;               // set beats clear
                resPos   <= peakPos;
                resCount <= peakCount;
            end else if (clearDone) begin
                done <= 1'b0;
            end
        end
    end

    always_comb begin
        apbRsp        = '0;
        apbRsp.pready = 1'b1;
        if (rdAccess) begin
            case (apbReq.paddr)
                sifhPkg::REG_STATUS: apbRsp.prdata = {30'd0, done, busy};
                sifhPkg::REG_RESULT: apbRsp.prdata = {16'd0, resCount, resPos};
                default:             apbRsp.prdata = '0;  // start reads back 0
            endcase
        end
    end

endmodule

/* rtl/sifhCtrl.sv */
`timescale 1ns/10ps

module sifhCtrl (
    input  logic                clk,
    input  logic                res,
    input  logic                start,
    input  sifhPkg::timestamp_t data,
    input  logic                dataValid,
    output logic                tdcEnable,
    output sifhPkg::ramWr_t     wr,
    output sifhPkg::ramRd_t     rd,
    input  sifhPkg::count_t     rdata,
    output logic                busy,
    output logic                finish,
    output sifhPkg::peakPos_t   peakPos,
    output sifhPkg::count_t     peakCount
);

    sifhPkg::ctrlState_t state;
    sifhPkg::ctrlState_t nextState;
    sifhPkg::frameCnt_t  cnt;                       // clear address or frame count
    sifhPkg::binIdx_t    window;
    logic                building;
    logic                accept;
    logic                clearLast;
    logic                bStart;
    logic                bDone;
    logic                pfDone;
    sifhPkg::ramWr_t     bWr;
    sifhPkg::ramRd_t     bRd;
    sifhPkg::ramRd_t     pfRd;
    sifhPkg::ramAddr_t   pfBase;
    sifhPkg::binIdx_t    pfBin;

    assign building  = state == sifhPkg::COARSE || state == sifhPkg::FINE;
    assign tdcEnable = building && cnt != sifhPkg::frameCnt_t'(sifhPkg::FRAME_LEN);
    assign accept    = tdcEnable && dataValid;
    assign clearLast = state == sifhPkg::CLEAR &&
                       cnt == sifhPkg::frameCnt_t'(sifhPkg::RAM_WORDS - 1);
    assign bStart    = clearLast || (state == sifhPkg::COARSE_PEAK && pfDone);
    assign pfBase    = (state == sifhPkg::FINE_PEAK) ? sifhPkg::FINE_BASE
                                                      : sifhPkg::COARSE_BASE;
    assign busy      = state != sifhPkg::IDLE;
    assign finish    = state == sifhPkg::FINE_PEAK && pfDone;
    assign peakPos   = {window, pfBin};

    always_comb begin
        nextState = state;
        case (state)
            sifhPkg::IDLE:        if (start)     nextState = sifhPkg::CLEAR;
            sifhPkg::CLEAR:       if (clearLast) nextState = sifhPkg::COARSE;
            sifhPkg::COARSE:      if (bDone)     nextState = sifhPkg::COARSE_PEAK;
            sifhPkg::COARSE_PEAK: if (pfDone)    nextState = sifhPkg::FINE;
            sifhPkg::FINE:        if (bDone)     nextState = sifhPkg::FINE_PEAK;
            sifhPkg::FINE_PEAK:   if (pfDone)    nextState = sifhPkg::IDLE;
            default:                             nextState = sifhPkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= sifhPkg::IDLE;
            cnt   <= '0;
        end else begin
            state <= nextState;
            if (bStart || state == sifhPkg::IDLE) begin
                cnt <= '0;
            end else if (state == sifhPkg::CLEAR || accept) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // coarse peak becomes the fine window
    always_ff @(posedge clk) begin
        if (state == sifhPkg::COARSE_PEAK && pfDone) begin
            window <= pfBin;
        end
    end

    // SRAM port owner per state
    always_comb begin
        wr = '0;
        rd = '0;
        case (state)
            sifhPkg::CLEAR: begin
                wr.we   = 1'b1;
                wr.addr = cnt[sifhPkg::RAM_AW-1:0];
                wr.data = '0;
            end
            sifhPkg::COARSE, sifhPkg::FINE: begin
                wr = bWr;
                rd = bRd;
            end
            sifhPkg::COARSE_PEAK, sifhPkg::FINE_PEAK: begin
                rd = pfRd;
            end
            default: begin
                wr = '0;
            end
        endcase
    end

    histBuilder uBuilder (
        .clk         (clk),
        .res         (res),
        .start       (bStart),
        .fine        (state == sifhPkg::FINE),
        .window      (window),
        .sampleValid (accept),
        .sample      (data),
        .wr          (bWr),
        .rd          (bRd),
        .rdata       (rdata),
        .done        (bDone)
    );

    peakFinder uPeak (
        .clk       (clk),
        .res       (res),
        .start     (bDone),                         // scan once the build has drained
        .base      (pfBase),
        .rd        (pfRd),
        .rdata     (rdata),
        .peakBin   (pfBin),
        .peakCount (peakCount),
        .done      (pfDone)
    );

endmodule

/* rtl/peakFinder.sv */
`timescale 1ns/10ps

module peakFinder (
    input  logic              clk,
    input  logic              res,
    input  logic              start,
    input  sifhPkg::ramAddr_t base,
    output sifhPkg::ramRd_t   rd,
    input  sifhPkg::count_t   rdata,
    output sifhPkg::binIdx_t  peakBin,
    output sifhPkg::count_t   peakCount,
    output logic              done
);

    logic             reading;
    sifhPkg::binIdx_t idx;
    logic             rdValid;
    sifhPkg::binIdx_t rdIdx;

    assign rd.re   = reading;
    assign rd.addr = base + sifhPkg::ramAddr_t'(idx);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            reading <= 1'b0;
            idx     <= '0;
            rdValid <= 1'b0;
            done    <= 1'b0;
        end else begin
            rdValid <= reading;                     // data follows one cycle later
            done    <= rdValid && rdIdx == sifhPkg::binIdx_t'(sifhPkg::NUM_BINS - 1);
            if (start) begin
                reading <= 1'b1;
                idx     <= '0;
            end else if (reading) begin
                if (idx == sifhPkg::binIdx_t'(sifhPkg::NUM_BINS - 1)) begin
                    reading <= 1'b0;
                end
                idx <= idx + 1'b1;
            end
        end
    end

    // strictly greater keeps the lowest index on a tie
    always_ff @(posedge clk) begin
        rdIdx <= idx;
        if (start) begin
            peakBin   <= '0;
            peakCount <= '0;
        end else if (rdValid && rdata > peakCount) begin
            peakBin   <= rdIdx;
            peakCount <= rdata;
        end
    end

endmodule

/* histogram/histBuilder.sv */
`timescale 1ns/10ps

module histBuilder (
    input  logic                clk,
    input  logic                res,
    input  logic                start,
    input  logic                fine,
    input  sifhPkg::binIdx_t    window,
    input  logic                sampleValid,
    input  sifhPkg::timestamp_t sample,
    output sifhPkg::ramWr_t     wr,
    output sifhPkg::ramRd_t     rd,
    input  sifhPkg::count_t     rdata,
    output logic                done
);

    sifhPkg::binIdx_t   coarseBin;
    sifhPkg::binIdx_t   fineBin;
    sifhPkg::binIdx_t   bin;
    sifhPkg::ramAddr_t  base;
    sifhPkg::ramAddr_t  inAddr;
    logic               keep;
    sifhPkg::frameCnt_t accepted;
    logic               lastSeen;
    logic               s1Valid;
    logic               s2Valid;
    logic               fwdValid;
    sifhPkg::ramAddr_t  s1Addr;
    sifhPkg::ramAddr_t  s2Addr;
    sifhPkg::ramAddr_t  fwdAddr;
    sifhPkg::count_t    fwdData;
    sifhPkg::count_t    oldCount;

    assign coarseBin = sample[sifhPkg::TS_W-1 -: sifhPkg::BIN_W];
    assign fineBin   = sample[sifhPkg::TS_W-sifhPkg::BIN_W-1 -: sifhPkg::BIN_W];
    assign bin       = fine ? fineBin : coarseBin;
    assign base      = fine ? sifhPkg::FINE_BASE : sifhPkg::COARSE_BASE;
    assign inAddr    = base + sifhPkg::ramAddr_t'(bin);

    // fine pass only counts samples inside the coarse peak bin
    assign keep = sampleValid && (!fine || coarseBin == window);

    // read stage, skipped when the bin is being written right now
    assign rd.re   = s1Valid && !(s2Valid && s2Addr == s1Addr);
    assign rd.addr = s1Addr;

    // increment stage
    assign oldCount = (fwdValid && fwdAddr == s2Addr) ? fwdData : rdata; // forward last write
    assign wr.we    = s2Valid;
    assign wr.addr  = s2Addr;
    assign wr.data  = oldCount + sifhPkg::count_t'(1);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid  <= 1'b0;
            s2Valid  <= 1'b0;
            fwdValid <= 1'b0;
            lastSeen <= 1'b0;
            done     <= 1'b0;
            accepted <= '0;
        end else begin
            s1Valid  <= keep;
            s2Valid  <= s1Valid;
            fwdValid <= s2Valid;
            lastSeen <= sampleValid &&
                        accepted == sifhPkg::frameCnt_t'(sifhPkg::FRAME_LEN - 1);
            done     <= lastSeen;                   // last write lands with this pulse
            if (start) begin
                accepted <= '0;
            end else if (sampleValid) begin
                accepted <= accepted + 1'b1;        // filtered samples count too
            end
        end
    end

    always_ff @(posedge clk) begin
        s1Addr  <= inAddr;
        s2Addr  <= s1Addr;
        fwdAddr <= s2Addr;
        fwdData <= wr.data;
    end

endmodule

/* histogram/histRam.sv */
`timescale 1ns/10ps

// histogram storage, coarse bins in the lower half and fine bins in the upper half
module histRam (
    input  logic             clk,
    input  sifhPkg::ramWr_t  wr,
    input  sifhPkg::ramRd_t  rd,
    output sifhPkg::count_t  rdata
);

    sifhPkg::count_t mem [sifhPkg::RAM_WORDS];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read port, old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (rd.re) begin
            rdata <= mem[rd.addr];
        end
    end

endmodule

/* common/sifhPkg.sv */
package sifhPkg;

    // timestamp and histogram geometry
    localparam int TS_W      = 12;
    localparam int BIN_W     = 4;                   // bits per pass
    localparam int NUM_BINS  = 16;
    localparam int RAM_AW    = 5;
    localparam int RAM_WORDS = 32;
    localparam int CNT_W     = 8;
    localparam int FRAME_LEN = 64;                  // accepted samples per pass
    localparam int FRAME_CW  = $clog2(FRAME_LEN + 1);

    typedef logic [TS_W-1:0]      timestamp_t;
    typedef logic [BIN_W-1:0]     binIdx_t;
    typedef logic [RAM_AW-1:0]    ramAddr_t;
    typedef logic [CNT_W-1:0]     count_t;
    typedef logic [FRAME_CW-1:0]  frameCnt_t;
    typedef logic [2*BIN_W-1:0]   peakPos_t;        // coarse bin above fine bin
    typedef logic [7:0]           apbAddr_t;
    typedef logic [31:0]          apbData_t;

    // SRAM regions
    localparam ramAddr_t COARSE_BASE = 5'd0;
    localparam ramAddr_t FINE_BASE   = 5'd16;

    typedef struct packed {
        logic     psel;
        logic     penable;
        logic     pwrite;
        apbAddr_t paddr;
        apbData_t pwdata;
    } apbReq_t;

    typedef struct packed {
        apbData_t prdata;
        logic     pready;
        logic     pslverr;
    } apbRsp_t;

    typedef struct packed {
        logic     we;
        ramAddr_t addr;
        count_t   data;
    } ramWr_t;

    typedef struct packed {
        logic     re;
        ramAddr_t addr;
    } ramRd_t;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        COARSE,
        COARSE_PEAK,
        FINE,
        FINE_PEAK
    } ctrlState_t;

    // register map
    localparam apbAddr_t REG_CTRL   = 8'h00;      // bit0 start
    localparam apbAddr_t REG_STATUS = 8'h04;      // bit0 busy, bit1 done
    localparam apbAddr_t REG_RESULT = 8'h08;      // 15:8 count, 7:0 position

endpackage
